// ==== rtl/dev_cfg.svh ====
`ifndef DEV_CFG_SVH
`define DEV_CFG_SVH

// Bus widths.
`define DEV_ALEN        32
`define DEV_DLEN        32
`define DEV_MLEN        4

// Target windows.
`define SRAM_BASE_LSB   28
`define SRAM_BASE_ADDR  4'h1
`define SLC_BASE_LSB    26
`define SLC_BASE_ADDR   6'h2

// SRAM word address width for 256 words.
`define SRAM_AW         8

// Reset vector points at the ROM window.
`define RST_VEC_DEF     32'h0400_0000

// Response buffer.
`define RSP_FIFO_DEPTH  4
`define RSP_CNT_W       3

`endif

// ==== rtl/dev_pkg.sv ====
package dev_pkg;

    // Decoded bus target.
    typedef enum logic [1:0] {
        SLV_SRAM = 2'd0,
        SLV_SLC  = 2'd1,
        SLV_NONE = 2'd2
    } dev_slv_e;

    // Response exception code.
    typedef enum logic [1:0] {
        EXCP_NONE    = 2'd0,
        EXCP_DEC_ERR = 2'd1
    } dev_excp_e;

    // SLC word offsets, address bits 3:2.
    // Offsets 2 and 3 are unmapped.
    typedef enum logic [1:0] {
        SLC_RST_VEC = 2'd0,
        SLC_SFT_IRQ = 2'd1
    } slc_reg_e;

endpackage

// ==== rtl/dev_bus_dec.sv ====
`timescale 1ns/100ps

`include "dev_cfg.svh"

module dev_bus_dec (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    req_vld,
    input  logic                    req_read,
    input  logic [`DEV_ALEN-1:0]    req_addr,
    input  logic [`DEV_MLEN-1:0]    req_mask,
    input  logic [`DEV_DLEN-1:0]    req_data,
    input  logic [`RSP_CNT_W-1:0]   free_cnt,
    input  logic [`DEV_DLEN-1:0]    sram_rd_data,
    input  logic [`DEV_DLEN-1:0]    slc_rd_data,
    input  logic                    slc_rd_err,
    output logic                    req_rdy,
    output logic                    sram_en,
    output logic                    slc_en,
    output logic                    tgt_read,
    output logic [`DEV_ALEN-1:0]    tgt_offset,
    output logic [`DEV_MLEN-1:0]    tgt_mask,
    output logic [`DEV_DLEN-1:0]    tgt_data,
    output logic                    push,
    output dev_pkg::dev_excp_e      push_excp,
    output logic [`DEV_DLEN-1:0]    push_data
);

    logic                   acc;
    logic                   sram_hit;
    logic                   slc_hit;
    dev_pkg::dev_slv_e      slv;
    dev_pkg::dev_slv_e      slv_q;

    //********************
    // Request side.
    //********************

    // Keep one slot back for the push already in flight.
    assign req_rdy  = free_cnt > {{(`RSP_CNT_W-1){1'b0}}, push};
    assign acc      = req_vld && req_rdy;

    assign sram_hit = req_addr[`DEV_ALEN-1:`SRAM_BASE_LSB] == `SRAM_BASE_ADDR;
    assign slc_hit  = req_addr[`DEV_ALEN-1:`SLC_BASE_LSB] == `SLC_BASE_ADDR;

    always_comb begin
        tgt_offset = '0;
        if (sram_hit) begin
            slv = dev_pkg::SLV_SRAM;
            tgt_offset[`SRAM_BASE_LSB-1:0] = req_addr[`SRAM_BASE_LSB-1:0];
        end else if (slc_hit) begin
            slv = dev_pkg::SLV_SLC;
            tgt_offset[`SLC_BASE_LSB-1:0] = req_addr[`SLC_BASE_LSB-1:0];
        end else begin
            slv = dev_pkg::SLV_NONE;
        end
    end

    assign sram_en  = acc && (slv == dev_pkg::SLV_SRAM);
    assign slc_en   = acc && (slv == dev_pkg::SLV_SLC);
    assign tgt_read = req_read;
    assign tgt_mask = req_mask;
    assign tgt_data = req_data;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            push  <= 1'b0;
            slv_q <= dev_pkg::SLV_NONE;
        end else begin
            push  <= acc;
            slv_q <= slv;
        end
    end

    //********************
    // Response side.
    //********************

    always_comb begin
        case (slv_q)
            dev_pkg::SLV_SRAM: begin
                push_excp = dev_pkg::EXCP_NONE;
                push_data = sram_rd_data;
            end
            dev_pkg::SLV_SLC: begin
                push_excp = slc_rd_err ? dev_pkg::EXCP_DEC_ERR : dev_pkg::EXCP_NONE;
                push_data = slc_rd_data;
            end
            default: begin
                push_excp = dev_pkg::EXCP_DEC_ERR;
                push_data = '0;
            end
        endcase
    end

    // An address hits at most one target window.
    a_one_target: assert property (@(posedge sys_clk) disable iff (!rst_n)
        req_vld |-> !(sram_hit && slc_hit));

endmodule

// ==== rtl/dev_sram.sv ====
`timescale 1ns/100ps

`include "dev_cfg.svh"

module dev_sram (
    input  logic                    sys_clk,
    input  logic                    sram_en,
    input  logic                    tgt_read,
    input  logic [`DEV_ALEN-1:0]    tgt_offset,
    input  logic [`DEV_MLEN-1:0]    tgt_mask,
    input  logic [`DEV_DLEN-1:0]    tgt_data,
    output logic [`DEV_DLEN-1:0]    sram_rd_data
);

    localparam int DEPTH = 2 ** `SRAM_AW;

    logic [`DEV_DLEN-1:0]   mem [DEPTH];
    logic [`SRAM_AW-1:0]    word_idx;

    // Word index. Upper offset bits alias.
    assign word_idx = tgt_offset[`SRAM_AW+1:2];

    // Byte-masked write.
    always_ff @(posedge sys_clk) begin
        if (sram_en && !tgt_read) begin
            for (int i = 0; i < `DEV_MLEN; i++) begin
                if (tgt_mask[i]) begin
                    mem[word_idx][8*i +: 8] <= tgt_data[8*i +: 8];
                end
            end
        end
    end

    // Registered read. Writes return zero.
    always_ff @(posedge sys_clk) begin
        if (sram_en) begin
            if (tgt_read) begin
                sram_rd_data <= mem[word_idx];
            end else begin
                sram_rd_data <= '0;
            end
        end
    end

endmodule

// ==== rtl/dev_slc.sv ====
`timescale 1ns/100ps

`include "dev_cfg.svh"

module dev_slc (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    slc_en,
    input  logic                    tgt_read,
    input  logic [`DEV_ALEN-1:0]    tgt_offset,
    input  logic [`DEV_MLEN-1:0]    tgt_mask,
    input  logic [`DEV_DLEN-1:0]    tgt_data,
    output logic [`DEV_DLEN-1:0]    slc_rd_data,
    output logic                    slc_rd_err,
    output logic [`DEV_ALEN-1:0]    rst_vec,
    output logic                    sft_irq
);

    dev_pkg::slc_reg_e      reg_sel;
    logic [`DEV_DLEN-1:0]   reg_val;
    logic                   mapped;

    assign reg_sel = dev_pkg::slc_reg_e'(tgt_offset[3:2]);

    always_comb begin
        mapped  = 1'b1;
        case (reg_sel)
            dev_pkg::SLC_RST_VEC: reg_val = rst_vec;
            dev_pkg::SLC_SFT_IRQ: reg_val = {{(`DEV_DLEN-1){1'b0}}, sft_irq};
            default: begin
                reg_val = '0;
                mapped  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rst_vec <= `RST_VEC_DEF;
            sft_irq <= 1'b0;
        end else if (slc_en && !tgt_read) begin
            case (reg_sel)
                dev_pkg::SLC_RST_VEC: begin
                    for (int i = 0; i < `DEV_MLEN; i++) begin
                        if (tgt_mask[i]) begin
                            rst_vec[8*i +: 8] <= tgt_data[8*i +: 8];
                        end
                    end
                end
                dev_pkg::SLC_SFT_IRQ: begin
                    if (tgt_mask[0]) begin
                        sft_irq <= tgt_data[0];
                    end
                end
                default: ;
            endcase
        end
    end

    // Read data one cycle after the strobe.
    always_ff @(posedge sys_clk) begin
        if (slc_en) begin
            slc_rd_data <= tgt_read ? reg_val : '0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            slc_rd_err <= 1'b0;
        end else if (slc_en) begin
            slc_rd_err <= !mapped;
        end
    end

    a_rst_vec_def: assert property (@(posedge sys_clk)
        !rst_n |=> (rst_vec == `RST_VEC_DEF) && !sft_irq);

endmodule

// ==== rtl/dev_rsp_fifo.sv ====
`timescale 1ns/100ps

`include "dev_cfg.svh"

module dev_rsp_fifo (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  dev_pkg::dev_excp_e      push_excp,
    input  logic [`DEV_DLEN-1:0]    push_data,
    input  logic                    rsp_rdy,
    output logic                    rsp_vld,
    output dev_pkg::dev_excp_e      rsp_excp,
    output logic [`DEV_DLEN-1:0]    rsp_data,
    output logic [`RSP_CNT_W-1:0]   free_cnt
);

    localparam int PW = $clog2(`RSP_FIFO_DEPTH);
    localparam int CW = `RSP_CNT_W;
    localparam logic [PW-1:0] LAST_C  = PW'(`RSP_FIFO_DEPTH - 1);
    localparam logic [CW-1:0] DEPTH_C = CW'(`RSP_FIFO_DEPTH);

    dev_pkg::dev_excp_e     excp_mem [`RSP_FIFO_DEPTH];
    logic [`DEV_DLEN-1:0]   data_mem [`RSP_FIFO_DEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [CW-1:0]          cnt;
    logic                   pop;

    assign rsp_vld  = cnt != '0;
    assign pop      = rsp_vld && rsp_rdy;
    assign rsp_excp = excp_mem[rd_ptr];
    assign rsp_data = data_mem[rd_ptr];
    assign free_cnt = DEPTH_C - cnt;

    always_ff @(posedge sys_clk) begin
        if (push) begin
            excp_mem[wr_ptr] <= push_excp;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_C) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_C) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    // Decoder flow control must keep a free slot for every push.
    a_no_overflow: assert property (@(posedge sys_clk) disable iff (!rst_n)
        push |-> cnt != DEPTH_C);

endmodule

// ==== rtl/dev_subsys.sv ====
`timescale 1ns/100ps

`include "dev_cfg.svh"

module dev_subsys (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    dev_req_vld,
    output logic                    dev_req_rdy,
    input  logic                    dev_req_read,
    input  logic [`DEV_ALEN-1:0]    dev_req_addr,
    input  logic [`DEV_MLEN-1:0]    dev_req_mask,
    input  logic [`DEV_DLEN-1:0]    dev_req_data,
    output logic                    dev_rsp_vld,
    input  logic                    dev_rsp_rdy,
    output dev_pkg::dev_excp_e      dev_rsp_excp,
    output logic [`DEV_DLEN-1:0]    dev_rsp_data,
    output logic [`DEV_ALEN-1:0]    rst_vec,
    output logic                    sft_irq
);

    logic                   sram_en;
    logic                   slc_en;
    logic                   tgt_read;
    logic [`DEV_ALEN-1:0]   tgt_offset;
    logic [`DEV_MLEN-1:0]   tgt_mask;
    logic [`DEV_DLEN-1:0]   tgt_data;
    logic [`DEV_DLEN-1:0]   sram_rd_data;
    logic [`DEV_DLEN-1:0]   slc_rd_data;
    logic                   slc_rd_err;
    logic                   push;
    dev_pkg::dev_excp_e     push_excp;
    logic [`DEV_DLEN-1:0]   push_data;
    logic [`RSP_CNT_W-1:0]  free_cnt;

    //********************
    // Address decoder.
    //********************
    dev_bus_dec u_bus_dec (
        .sys_clk        ( sys_clk       ),
        .rst_n          ( rst_n         ),
        .req_vld        ( dev_req_vld   ),
        .req_read       ( dev_req_read  ),
        .req_addr       ( dev_req_addr  ),
        .req_mask       ( dev_req_mask  ),
        .req_data       ( dev_req_data  ),
        .free_cnt       ( free_cnt      ),
        .sram_rd_data   ( sram_rd_data  ),
        .slc_rd_data    ( slc_rd_data   ),
        .slc_rd_err     ( slc_rd_err    ),
        .req_rdy        ( dev_req_rdy   ),
        .sram_en        ( sram_en       ),
        .slc_en         ( slc_en        ),
        .tgt_read       ( tgt_read      ),
        .tgt_offset     ( tgt_offset    ),
        .tgt_mask       ( tgt_mask      ),
        .tgt_data       ( tgt_data      ),
        .push           ( push          ),
        .push_excp      ( push_excp     ),
        .push_data      ( push_data     )
    );

    //********************
    // Targets.
    //********************
    dev_sram u_sram (
        .sys_clk        ( sys_clk       ),
        .sram_en        ( sram_en       ),
        .tgt_read       ( tgt_read      ),
        .tgt_offset     ( tgt_offset    ),
        .tgt_mask       ( tgt_mask      ),
        .tgt_data       ( tgt_data      ),
        .sram_rd_data   ( sram_rd_data  )
    );

    dev_slc u_slc (
        .sys_clk        ( sys_clk       ),
        .rst_n          ( rst_n         ),
        .slc_en         ( slc_en        ),
        .tgt_read       ( tgt_read      ),
        .tgt_offset     ( tgt_offset    ),
        .tgt_mask       ( tgt_mask      ),
        .tgt_data       ( tgt_data      ),
        .slc_rd_data    ( slc_rd_data   ),
        .slc_rd_err     ( slc_rd_err    ),
        .rst_vec        ( rst_vec       ),
        .sft_irq        ( sft_irq       )
    );

    // Responses back to the master in order.
    dev_rsp_fifo u_rsp_fifo (
        .sys_clk        ( sys_clk       ),
        .rst_n          ( rst_n         ),
        .push           ( push          ),
        .push_excp      ( push_excp     ),
        .push_data      ( push_data     ),
        .rsp_rdy        ( dev_rsp_rdy   ),
        .rsp_vld        ( dev_rsp_vld   ),
        .rsp_excp       ( dev_rsp_excp  ),
        .rsp_data       ( dev_rsp_data  ),
        .free_cnt       ( free_cnt      )
    );

endmodule

// ==== testbench/tb_dev_subsys.sv ====
`timescale 1ns/100ps

`include "dev_cfg.svh"

module tb_dev_subsys;

    localparam int N_FILL = 256;
    localparam int N_SRAM = 300;
    localparam int N_SLC  = 40;
    localparam int N_ERR  = 40;
    localparam int N_MIX  = 200;
    localparam int N_REQ  = 1 + N_FILL + N_SRAM + N_SLC + N_ERR + N_MIX;
    localparam int WATCHDOG_CYC = N_REQ * 20 + 200;

    logic                   sys_clk;
    logic                   rst_n;
    logic                   dev_req_vld;
    logic                   dev_req_rdy;
    logic                   dev_req_read;
    logic [`DEV_ALEN-1:0]   dev_req_addr;
    logic [`DEV_MLEN-1:0]   dev_req_mask;
    logic [`DEV_DLEN-1:0]   dev_req_data;
    logic                   dev_rsp_vld;
    logic                   dev_rsp_rdy;
    dev_pkg::dev_excp_e     dev_rsp_excp;
    logic [`DEV_DLEN-1:0]   dev_rsp_data;
    logic [`DEV_ALEN-1:0]   rst_vec;
    logic                   sft_irq;

    integer                 seed;
    logic                   stall_mode;
    int                     req_cnt;
    int                     rsp_cnt;

    // Reference model state.
    logic [`DEV_DLEN-1:0]   m_sram [2**`SRAM_AW];
    logic [`DEV_ALEN-1:0]   m_rst_vec;
    logic                   m_sft_irq;
    dev_pkg::dev_excp_e     exp_excp_q [$];
    logic [`DEV_DLEN-1:0]   exp_data_q [$];

    dev_subsys i_dev_subsys (
        .sys_clk        ( sys_clk       ),
        .rst_n          ( rst_n         ),
        .dev_req_vld    ( dev_req_vld   ),
        .dev_req_rdy    ( dev_req_rdy   ),
        .dev_req_read   ( dev_req_read  ),
        .dev_req_addr   ( dev_req_addr  ),
        .dev_req_mask   ( dev_req_mask  ),
        .dev_req_data   ( dev_req_data  ),
        .dev_rsp_vld    ( dev_rsp_vld   ),
        .dev_rsp_rdy    ( dev_rsp_rdy   ),
        .dev_rsp_excp   ( dev_rsp_excp  ),
        .dev_rsp_data   ( dev_rsp_data  ),
        .rst_vec        ( rst_vec       ),
        .sft_irq        ( sft_irq       )
    );

    always #4 sys_clk = ~sys_clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    //********************
    // Compare tasks.
    //********************
    task automatic check_rsp(input dev_pkg::dev_excp_e exp_excp,
                             input logic [`DEV_DLEN-1:0] exp_data);
        if (dev_rsp_excp !== exp_excp) begin
            fail_run($sformatf("ERROR dev_rsp_excp expected %h got %h", exp_excp, dev_rsp_excp));
        end else if (dev_rsp_data !== exp_data) begin
            fail_run($sformatf("ERROR dev_rsp_data expected %h got %h", exp_data, dev_rsp_data));
        end
    endtask

    task automatic check_ctrl(input logic [`DEV_ALEN-1:0] exp_rst_vec, input logic exp_sft_irq);
        if (rst_vec !== exp_rst_vec) begin
            fail_run($sformatf("ERROR rst_vec expected %h got %h", exp_rst_vec, rst_vec));
        end else if (sft_irq !== exp_sft_irq) begin
            fail_run($sformatf("ERROR sft_irq expected %h got %h", exp_sft_irq, sft_irq));
        end
    endtask

    //********************
    // Reference model.
    //********************
    function automatic logic [`DEV_DLEN-1:0] byte_merge(input logic [`DEV_DLEN-1:0] old,
                                                        input logic [`DEV_DLEN-1:0] wdata,
                                                        input logic [`DEV_MLEN-1:0] mask);
        logic [`DEV_DLEN-1:0] res;
        res = old;
        for (int b = 0; b < `DEV_MLEN; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Applies one accepted request and queues its expected response.
    task automatic model_access(input logic read, input logic [`DEV_ALEN-1:0] addr,
                                input logic [`DEV_MLEN-1:0] mask,
                                input logic [`DEV_DLEN-1:0] data);
        logic [`SRAM_AW-1:0]    idx;
        dev_pkg::dev_excp_e     excp;
        logic [`DEV_DLEN-1:0]   rdata;
        idx   = addr[`SRAM_AW+1:2];
        excp  = dev_pkg::EXCP_NONE;
        rdata = '0;
        if (addr[`DEV_ALEN-1:`SRAM_BASE_LSB] == `SRAM_BASE_ADDR) begin
            if (read) begin
                rdata = m_sram[idx];
            end else begin
                m_sram[idx] = byte_merge(m_sram[idx], data, mask);
            end
        end else if (addr[`DEV_ALEN-1:`SLC_BASE_LSB] == `SLC_BASE_ADDR) begin
            if (addr[3:2] == dev_pkg::SLC_RST_VEC) begin
                if (read) begin
                    rdata = m_rst_vec;
                end else begin
                    m_rst_vec = byte_merge(m_rst_vec, data, mask);
                end
            end else if (addr[3:2] == dev_pkg::SLC_SFT_IRQ) begin
                if (read) begin
                    rdata = {{(`DEV_DLEN-1){1'b0}}, m_sft_irq};
                end else if (mask[0]) begin
                    m_sft_irq = data[0];
                end
            end else begin
                excp = dev_pkg::EXCP_DEC_ERR;
            end
        end else begin
            excp = dev_pkg::EXCP_DEC_ERR;
        end
        exp_excp_q.push_back(excp);
        exp_data_q.push_back(rdata);
    endtask

    //********************
    // Stimulus.
    //********************
    // Called 1 ns after a rising edge; returns 1 ns after the accepting edge.
    task automatic send_req(input logic read, input logic [`DEV_ALEN-1:0] addr,
                            input logic [`DEV_MLEN-1:0] mask, input logic [`DEV_DLEN-1:0] data);
        logic acc;
        dev_req_vld  = 1'b1;
        dev_req_read = read;
        dev_req_addr = addr;
        dev_req_mask = mask;
        dev_req_data = data;
        acc = 1'b0;
        while (!acc) begin
            @(negedge sys_clk);
            acc = dev_req_rdy;
            @(posedge sys_clk);
            #1;
        end
        model_access(read, addr, mask, data);
        dev_req_vld = 1'b0;
        req_cnt++;
    endtask

    task automatic maybe_idle;
        if (($random(seed) & 7) == 0) begin
            @(posedge sys_clk);
            #1;
        end
    endtask

    task automatic pick_bad_addr(output logic [`DEV_ALEN-1:0] addr);
        addr = $random(seed);
        while (addr[`DEV_ALEN-1:`SRAM_BASE_LSB] == `SRAM_BASE_ADDR ||
               addr[`DEV_ALEN-1:`SLC_BASE_LSB] == `SLC_BASE_ADDR) begin
            addr = $random(seed);
        end
    endtask

    task automatic pick_slc_addr(input logic [1:0] off, output logic [`DEV_ALEN-1:0] addr);
        addr = $random(seed);
        addr[`DEV_ALEN-1:`SLC_BASE_LSB] = `SLC_BASE_ADDR;
        addr[3:2] = off;
    endtask

    task automatic pick_sram_addr(output logic [`DEV_ALEN-1:0] addr);
        addr = $random(seed);
        addr[`DEV_ALEN-1:`SRAM_BASE_LSB] = `SRAM_BASE_ADDR;
    endtask

    // Full-mask fill so that no SRAM word is read undefined.
    task automatic fill_sram;
        logic [7:0] idx;
        for (int i = 0; i < N_FILL; i++) begin
            idx = i[7:0];
            send_req(1'b0, 32'h1000_0000 | (32'(i) << 2), 4'hf,
                     {~idx, idx, idx ^ 8'h5a, idx + 8'h11});
        end
    endtask

    task automatic random_access(input int kind);
        logic [`DEV_ALEN-1:0] addr;
        if (kind < 2) begin
            pick_sram_addr(addr);
        end else if (kind == 2) begin
            pick_slc_addr(2'($random(seed)), addr);
        end else begin
            pick_bad_addr(addr);
        end
        send_req(1'($random(seed)), addr, 4'($random(seed)), $random(seed));
    endtask

    task automatic slc_reg_ops;
        logic [`DEV_ALEN-1:0] addr;
        for (int i = 0; i < N_SLC; i++) begin
            pick_slc_addr((i % 4) < 2 ? 2'd0 : 2'd1, addr);
            send_req(i[0], addr, 4'($random(seed)), $random(seed));
        end
    endtask

    task automatic dec_err_ops;
        logic [`DEV_ALEN-1:0] addr;
        for (int i = 0; i < N_ERR; i++) begin
            if (i[0]) begin
                pick_bad_addr(addr);
            end else begin
                pick_slc_addr(2'd2 + 2'($random(seed) & 1), addr);
            end
            send_req(1'($random(seed)), addr, 4'($random(seed)), $random(seed));
        end
    endtask

    // Response back-pressure with long low stretches in stall mode.
    initial begin
        int hold;
        hold = 0;
        forever begin
            @(posedge sys_clk);
            #1;
            if (!stall_mode) begin
                dev_rsp_rdy = 1'b1;
            end else if (hold > 0) begin
                hold--;
            end else begin
                dev_rsp_rdy = !dev_rsp_rdy;
                hold = dev_rsp_rdy ? ($random(seed) & 3) : 4 + ($random(seed) & 15);
            end
        end
    end

    // Response and control monitor sampled mid-cycle.
    always @(negedge sys_clk) begin
        if (rst_n) begin
            check_ctrl(m_rst_vec, m_sft_irq);
            if (dev_rsp_vld && dev_rsp_rdy) begin
                if (exp_data_q.size() == 0) begin
                    fail_run("Response returned with no request outstanding.");
                end else begin
                    check_rsp(exp_excp_q.pop_front(), exp_data_q.pop_front());
                    rsp_cnt++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge sys_clk);
        fail_run("Watchdog expired before all responses returned.");
    end

    initial begin
        seed         = 32'h7f30_0d2b;
        sys_clk      = 1'b0;
        rst_n        = 1'b0;
        dev_req_vld  = 1'b0;
        dev_req_read = 1'b0;
        dev_req_addr = '0;
        dev_req_mask = '0;
        dev_req_data = '0;
        dev_rsp_rdy  = 1'b1;
        stall_mode   = 1'b0;
        req_cnt      = 0;
        rsp_cnt      = 0;
        m_rst_vec    = `RST_VEC_DEF;
        m_sft_irq    = 1'b0;
        repeat (5) @(posedge sys_clk);
        #1;
        rst_n = 1'b1;
        @(posedge sys_clk);
        #1;

        // Reset state.
        if (dev_rsp_vld !== 1'b0) begin
            fail_run($sformatf("ERROR dev_rsp_vld expected %h got %h", 1'b0, dev_rsp_vld));
        end
        if (dev_req_rdy !== 1'b1) begin
            fail_run($sformatf("ERROR dev_req_rdy expected %h got %h", 1'b1, dev_req_rdy));
        end
        check_ctrl(`RST_VEC_DEF, 1'b0);
        send_req(1'b1, 32'h0800_0000, 4'hf, '0);

        fill_sram();
        for (int i = 0; i < N_SRAM; i++) begin
            maybe_idle();
            random_access(0);
        end
        slc_reg_ops();
        dec_err_ops();

        stall_mode = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            maybe_idle();
            random_access($random(seed) & 3);
        end
        stall_mode = 1'b0;

        while (rsp_cnt != req_cnt) begin
            @(posedge sys_clk);
        end
        repeat (8) @(posedge sys_clk);
        if (rsp_cnt != req_cnt || exp_data_q.size() != 0) begin
            fail_run($sformatf("Response count %0d does not match request count %0d.",
                               rsp_cnt, req_cnt));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/dev_pkg.sv
rtl/dev_bus_dec.sv
rtl/dev_sram.sv
rtl/dev_slc.sv
rtl/dev_rsp_fifo.sv
rtl/dev_subsys.sv
testbench/tb_dev_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the device bus testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_dev_subsys

# The log decides the result, so a failing run must not stop the script here.
./obj_dir/Vtb_dev_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation reported failure."
    exit 1
fi

echo "Simulation finished without failure."
exit 0
